// ==== filelist.f ====
+incdir+.
mpAddPkg.sv
mpRegIf.sv
mpCarrySelectAdder.sv
mpOperandBank.sv
mpAddCtrl.sv
mpCycleCounter.sv
mpAxiLiteSlave.sv
mpModAdderTop.sv
mpModAdder_props.sv
tb_mpModAdder.sv

// ==== mpAddCtrl.sv ====
// Controller FSM sequencing the sum and reduce passes and the done flag
`default_nettype none

module mpAddCtrl
  import mpAddPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  logic     validOut,
  output addPass_e pass,
  output logic     validIn,
  output logic     captureT,
  output logic     commitResult,
  output logic     busy,
  output logic     done
);

  ctrlState_e state;
  ctrlState_e nextState;

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      IDLE:        if (start) nextState = SUM;
      SUM:         nextState = WAIT_SUM;
      WAIT_SUM:    if (validOut) nextState = REDUCE;
      REDUCE:      nextState = WAIT_REDUCE;
      WAIT_REDUCE: if (validOut) nextState = IDLE;
      default:     nextState = IDLE;
    endcase
  end

  assign validIn      = (state == SUM) || (state == REDUCE);
  assign pass         = (state == REDUCE || state == WAIT_REDUCE) ? PASS_REDUCE : PASS_SUM;
  assign captureT     = (state == WAIT_SUM) && validOut;     // T = A + B
  assign commitResult = (state == WAIT_REDUCE) && validOut;  // U = T + MNEG
  assign busy         = (state != IDLE);

  always_ff @(posedge clk)
  begin
    if (rst)
      done <= 1'b0;
    else if (start && state == IDLE)
      done <= 1'b0;
    else if (commitResult)
      done <= 1'b1;  // Sticky until next accepted start
  end

endmodule

`default_nettype wire

// ==== mpAddPkg.sv ====
// Pass-select and controller state types for the modular adder
`default_nettype none

package mpAddPkg;

  // Operand pair presented to the adder
  typedef enum logic {
    PASS_SUM,
    PASS_REDUCE
  } addPass_e;

  typedef enum logic [2:0] {
    IDLE,
    SUM,
    WAIT_SUM,
    REDUCE,
    WAIT_REDUCE
  } ctrlState_e;

endpackage

`default_nettype wire

// ==== mpAxiLiteSlave.sv ====
// AXI4-Lite slave turning bus transfers into register accesses and start strobes
`default_nettype none
`include "mp_params.svh"

module mpAxiLiteSlave (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`MP_ADDR_W-1:0] AWADDR,
  input  logic                  AWVALID,
  output logic                  AWREADY,
  input  logic [31:0]           WDATA,
  input  logic [3:0]            WSTRB,    // Full-word writes only
  input  logic                  WVALID,
  output logic                  WREADY,
  output logic [1:0]            BRESP,
  output logic                  BVALID,
  input  logic                  BREADY,
  input  logic [`MP_ADDR_W-1:0] ARADDR,
  input  logic                  ARVALID,
  output logic                  ARREADY,
  output logic [31:0]           RDATA,
  output logic [1:0]            RRESP,
  output logic                  RVALID,
  input  logic                  RREADY,
  mpRegIf.master                regs,
  output logic                  start
);

  localparam logic [`MP_ADDR_W-1:0] RegCtrl = `MP_REG_CTRL;

  logic wrAccept;  // One-cycle pulse on AW and W together
  logic rdAccept;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrAccept <= 1'b0;
      BVALID   <= 1'b0;
    end
    else
    begin
      wrAccept <= AWVALID && WVALID && !BVALID && !wrAccept;
      if (wrAccept)
        BVALID <= 1'b1;
      else if (BREADY)
        BVALID <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdAccept <= 1'b0;
      RVALID   <= 1'b0;
    end
    else
    begin
      rdAccept <= ARVALID && !RVALID && !rdAccept;
      if (rdAccept)
        RVALID <= 1'b1;  // Bank data registered by now
      else if (RREADY)
        RVALID <= 1'b0;
    end
  end

  assign AWREADY = wrAccept;
  assign WREADY  = wrAccept;
  assign BRESP   = 2'b00;
  assign ARREADY = rdAccept;
  assign RRESP   = 2'b00;
  assign RDATA   = regs.rdData;

  assign regs.wrEn   = wrAccept;
  assign regs.wrAddr = AWADDR;
  assign regs.wrData = WDATA;
  assign regs.rdEn   = rdAccept;
  assign regs.rdAddr = ARADDR;

  assign start = wrAccept && (AWADDR == RegCtrl) && WDATA[0];

endmodule

`default_nettype wire

// ==== mpCarrySelectAdder.sv ====
// Pipelined carry-select wide adder with one register stage
`default_nettype none
`include "mp_params.svh"

module mpCarrySelectAdder (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     validIn,
  input  logic [`MP_ADD_WIDTH-1:0] a,
  input  logic [`MP_ADD_WIDTH-1:0] b,
  output logic                     validOut,
  output logic [`MP_ADD_WIDTH:0]   sum
);

  localparam int NumLimbs = `MP_ADD_WIDTH / `MP_LIMB;

  logic [NumLimbs:1] carry;  // Selected carry into each limb

  for (genvar i = 0; i < NumLimbs; i++)
  begin : gLimb
    localparam int Lo = i * `MP_LIMB;
    localparam int Hi = (i == NumLimbs - 1) ? `MP_ADD_WIDTH : Lo + `MP_LIMB;  // Top limb is wider

    if (i == 0)
    begin : gPlain
      logic [Hi-Lo-1:0] regSum;
      logic             regCarry;

      always_ff @(posedge clk)
      begin
        {regCarry, regSum} <= a[Hi-1:Lo] + b[Hi-1:Lo];
      end

      assign sum[Hi-1:Lo] = regSum;
      assign carry[1]     = regCarry;
    end
    else
    begin : gSelect
      logic [Hi-Lo-1:0] regSum0;
      logic [Hi-Lo-1:0] regSum1;
      logic             regCarry0;
      logic             regCarry1;

      always_ff @(posedge clk)
      begin
        {regCarry0, regSum0} <= a[Hi-1:Lo] + b[Hi-1:Lo];          // Carry-in 0
        {regCarry1, regSum1} <= a[Hi-1:Lo] + b[Hi-1:Lo] + 1'b1;   // Carry-in 1
      end

      // Ripple through the select muxes after the register
      assign sum[Hi-1:Lo] = carry[i] ? regSum1 : regSum0;
      assign carry[i+1]   = carry[i] ? regCarry1 : regCarry0;
    end
  end

  assign sum[`MP_ADD_WIDTH] = carry[NumLimbs];

  always_ff @(posedge clk)
  begin
    if (rst)
      validOut <= 1'b0;
    else
      validOut <= validIn;
  end

endmodule

`default_nettype wire

// ==== mpCycleCounter.sv ====
// Busy-cycle counter for measuring operation latency
`default_nettype none

module mpCycleCounter (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  logic        busy,
  output logic [31:0] cycles
);

  always_ff @(posedge clk)
  begin
    if (rst)
      cycles <= '0;
    else if (start && !busy)
      cycles <= '0;  // Start is only accepted while idle
    else if (busy)
      cycles <= cycles + 32'd1;
  end

endmodule

`default_nettype wire

// ==== mpModAdderTop.sv ====
// Top level of the modular adder with AXI4-Lite host ports
`default_nettype none
`include "mp_params.svh"

module mpModAdderTop
  import mpAddPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`MP_ADDR_W-1:0] AWADDR,
  input  logic                  AWVALID,
  output logic                  AWREADY,
  input  logic [31:0]           WDATA,
  input  logic [3:0]            WSTRB,
  input  logic                  WVALID,
  output logic                  WREADY,
  output logic [1:0]            BRESP,
  output logic                  BVALID,
  input  logic                  BREADY,
  input  logic [`MP_ADDR_W-1:0] ARADDR,
  input  logic                  ARVALID,
  output logic                  ARREADY,
  output logic [31:0]           RDATA,
  output logic [1:0]            RRESP,
  output logic                  RVALID,
  input  logic                  RREADY
);

  logic                     start;
  addPass_e                 pass;
  logic                     validIn;
  logic                     validOut;
  logic                     captureT;
  logic                     commitResult;
  logic                     busy;
  logic                     done;
  logic [31:0]              cycles;
  logic [`MP_ADD_WIDTH-1:0] addA;
  logic [`MP_ADD_WIDTH-1:0] addB;
  logic [`MP_ADD_WIDTH:0]   addSum;

  mpRegIf regBus ();

  mpAxiLiteSlave uAxiSlave (
    .clk, .rst,
    .AWADDR, .AWVALID, .AWREADY, .WDATA, .WSTRB, .WVALID, .WREADY,
    .BRESP, .BVALID, .BREADY,
    .ARADDR, .ARVALID, .ARREADY, .RDATA, .RRESP, .RVALID, .RREADY,
    .regs (regBus.master),
    .start
  );

  mpOperandBank uBank (
    .clk, .rst,
    .regs (regBus.target),
    .pass, .captureT, .commitResult, .busy, .done, .cycles,
    .addA, .addB, .addSum
  );

  mpAddCtrl uCtrl (
    .clk, .rst, .start, .validOut,
    .pass, .validIn, .captureT, .commitResult, .busy, .done
  );

  mpCycleCounter uCounter (
    .clk, .rst, .start, .busy, .cycles
  );

  mpCarrySelectAdder uAdder (
    .clk, .rst, .validIn,
    .a (addA), .b (addB),
    .validOut,
    .sum (addSum)
  );

endmodule

`default_nettype wire

// ==== mpModAdder_props.sv ====
// Bound assertions on AXI4-Lite handshakes and controller status of the modular adder
`default_nettype none

module mpModAdderProps (
  input logic        clk,
  input logic        rst,
  input logic        AWVALID,
  input logic        WVALID,
  input logic        AWREADY,
  input logic        BVALID,
  input logic        BREADY,
  input logic        RVALID,
  input logic        RREADY,
  input logic [31:0] RDATA,
  input logic        busy,
  input logic        done
);
  timeunit 1ns;
  timeprecision 1ps;

  bValidHold: assert property (@(posedge clk) disable iff (rst)
    BVALID && !BREADY |=> BVALID)
    else $error("BVALID dropped before BREADY");

  rDataStable: assert property (@(posedge clk) disable iff (rst)
    RVALID && !RREADY |=> RVALID && $stable(RDATA))
    else $error("RDATA changed or RVALID dropped before RREADY");

  busyDoneExclusive: assert property (@(posedge clk) disable iff (rst)
    !(busy && done))
    else $error("busy and done high together");

  awReadyNeedsValid: assert property (@(posedge clk) disable iff (rst)
    AWREADY |-> AWVALID && WVALID)
    else $error("AWREADY without AWVALID and WVALID");

endmodule

bind mpModAdderTop mpModAdderProps uProps (
  .clk, .rst, .AWVALID, .WVALID, .AWREADY, .BVALID, .BREADY,
  .RVALID, .RREADY, .RDATA, .busy, .done
);

`default_nettype wire

// ==== mpOperandBank.sv ====
// Operand, intermediate and result registers with adder muxing and read decode
`default_nettype none
`include "mp_params.svh"

module mpOperandBank
  import mpAddPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  mpRegIf.target                   regs,
  input  addPass_e                 pass,
  input  logic                     captureT,
  input  logic                     commitResult,
  input  logic                     busy,
  input  logic                     done,
  input  logic [31:0]              cycles,
  output logic [`MP_ADD_WIDTH-1:0] addA,
  output logic [`MP_ADD_WIDTH-1:0] addB,
  input  logic [`MP_ADD_WIDTH:0]   addSum
);

  localparam int Span = `MP_WORDS * 32;
  localparam int Pad  = `MP_ADD_WIDTH - `MP_WIDTH;
  localparam logic [11:0] RegStatus = `MP_REG_STATUS;
  localparam logic [11:0] RegCycles = `MP_REG_CYCLES;
  localparam logic [11:0] BaseA     = `MP_BASE_A;
  localparam logic [11:0] BaseB     = `MP_BASE_B;
  localparam logic [11:0] BaseMneg  = `MP_BASE_MNEG;
  localparam logic [11:0] BaseRes   = `MP_BASE_RES;

  logic [Span-1:0]          opA;
  logic [Span-1:0]          opB;
  logic [Span-1:0]          opMneg;
  logic [`MP_ADD_WIDTH-1:0] tReg;
  logic [`MP_WIDTH-1:0]     res;
  logic [Span-1:0]          resWide;
  logic [5:0]               wrIdx;
  logic [5:0]               rdIdx;
  logic [31:0]              rdWord;

  assign wrIdx   = regs.wrAddr[7:2];
  assign rdIdx   = regs.rdAddr[7:2];
  assign resWide = {{(Span - `MP_WIDTH){1'b0}}, res};

  assign addA = (pass == PASS_SUM) ? {{Pad{1'b0}}, opA[`MP_WIDTH-1:0]} : tReg;
  assign addB = (pass == PASS_SUM) ? {{Pad{1'b0}}, opB[`MP_WIDTH-1:0]}
                                   : opMneg[`MP_ADD_WIDTH-1:0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      opA    <= '0;
      opB    <= '0;
      opMneg <= '0;
      tReg   <= '0;
      res    <= '0;
    end
    else
    begin
      if (regs.wrEn && wrIdx < `MP_WORDS)
      begin
        case (regs.wrAddr[11:8])
          BaseA[11:8]:    opA[wrIdx*32 +: 32]    <= regs.wrData;
          BaseB[11:8]:    opB[wrIdx*32 +: 32]    <= regs.wrData;
          BaseMneg[11:8]: opMneg[wrIdx*32 +: 32] <= regs.wrData;
          default: ;
        endcase
      end
      if (captureT)
        tReg <= addSum[`MP_ADD_WIDTH-1:0];
      if (commitResult)  // Carry out means T was at least M
        res <= addSum[`MP_ADD_WIDTH] ? addSum[`MP_WIDTH-1:0] : tReg[`MP_WIDTH-1:0];
    end
  end

  always_comb
  begin
    rdWord = '0;
    case (regs.rdAddr[11:8])
      RegStatus[11:8]:
        if (regs.rdAddr == RegStatus)
          rdWord = {30'd0, done, busy};
        else if (regs.rdAddr == RegCycles)
          rdWord = cycles;
      BaseA[11:8]:    if (rdIdx < `MP_WORDS) rdWord = opA[rdIdx*32 +: 32];
      BaseB[11:8]:    if (rdIdx < `MP_WORDS) rdWord = opB[rdIdx*32 +: 32];
      BaseMneg[11:8]: if (rdIdx < `MP_WORDS) rdWord = opMneg[rdIdx*32 +: 32];
      BaseRes[11:8]:  if (rdIdx < `MP_WORDS) rdWord = resWide[rdIdx*32 +: 32];
      default: ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      regs.rdData <= '0;
    else if (regs.rdEn)
      regs.rdData <= rdWord;  // Held until the next read
  end

endmodule

`default_nettype wire

// ==== mpRegIf.sv ====
// Register access interface between the bus slave and the operand bank
`default_nettype none
`include "mp_params.svh"

interface mpRegIf;

  logic                   wrEn;
  logic [`MP_ADDR_W-1:0]  wrAddr;
  logic [31:0]            wrData;
  logic                   rdEn;
  logic [`MP_ADDR_W-1:0]  rdAddr;
  logic [31:0]            rdData;  // Valid one cycle after rdEn

  modport master (output wrEn, wrAddr, wrData, rdEn, rdAddr, input rdData);
  modport target (input wrEn, wrAddr, wrData, rdEn, rdAddr, output rdData);

endinterface

`default_nettype wire

// ==== mp_params.svh ====
// Operand width, limb width, bus address width and register map macros
`ifndef MP_PARAMS_SVH
`define MP_PARAMS_SVH

`define MP_WIDTH       1027
`define MP_ADD_WIDTH   (`MP_WIDTH + 1)
`define MP_LIMB        64
`define MP_WORDS       33
`define MP_ADDR_W      12

`define MP_REG_CTRL    12'h000
`define MP_REG_STATUS  12'h004
`define MP_REG_CYCLES  12'h008
`define MP_BASE_A      12'h100
`define MP_BASE_B      12'h200
`define MP_BASE_MNEG   12'h300
`define MP_BASE_RES    12'h400

`endif

// ==== tb_mpModAdder.sv ====
// Testbench with clock, LFSR stimulus, AXI4-Lite tasks, modular-add model and checks
`default_nettype none
`include "mp_params.svh"

module tb_mpModAdder;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int Span    = `MP_WORDS * 32;
  localparam int Timeout = 100;

  logic                  clk;
  logic                  rst;
  logic [`MP_ADDR_W-1:0] AWADDR;
  logic                  AWVALID;
  logic                  AWREADY;
  logic [31:0]           WDATA;
  logic [3:0]            WSTRB;
  logic                  WVALID;
  logic                  WREADY;
  logic [1:0]            BRESP;
  logic                  BVALID;
  logic                  BREADY;
  logic [`MP_ADDR_W-1:0] ARADDR;
  logic                  ARVALID;
  logic                  ARREADY;
  logic [31:0]           RDATA;
  logic [1:0]            RRESP;
  logic                  RVALID;
  logic                  RREADY;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          readyBits;    // Width of random ready delays
  logic        doneLowSeen;

  mpModAdderTop u_mpModAdderTop (
    .clk, .rst,
    .AWADDR, .AWVALID, .AWREADY, .WDATA, .WSTRB, .WVALID, .WREADY,
    .BRESP, .BVALID, .BREADY,
    .ARADDR, .ARVALID, .ARREADY, .RDATA, .RRESP, .RVALID, .RREADY
  );

  always #50 clk = ~clk;

  always @(negedge clk)
  begin
    if (!u_mpModAdderTop.done)
      doneLowSeen <= 1'b1;  // Start must drop the sticky done flag
  end

  // Taps 32, 22, 2, 1
  function automatic logic nextBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [Span-1:0] randBits(input int n);
    logic [Span-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v[i] = nextBit();
    return v;
  endfunction

  function automatic int randDelay();
    int d;
    d = 0;
    for (int i = 0; i < readyBits; i++)
      d = (d << 1) | int'(nextBit());
    return d;
  endfunction

  task automatic checkWord(input string name, input logic [31:0] expected,
                           input logic [31:0] got);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("ERROR %s expected 0x%h got 0x%h", name, expected, got);
    end
  endtask

  task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data);
    int         n;
    logic [1:0] resp;
    @(posedge clk);
    AWADDR  <= addr;
    WDATA   <= data;
    AWVALID <= 1'b1;
    WVALID  <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!AWREADY && !WREADY && n < Timeout)
    begin
      @(negedge clk);
      n++;
    end
    if (n < Timeout)
    begin
      checkWord("AWREADY", 32'd1, {31'd0, AWREADY});
      checkWord("WREADY", 32'd1, {31'd0, WREADY});  // Pulses together with AWREADY
    end
    @(posedge clk);  // Handshake edge
    AWVALID <= 1'b0;
    WVALID  <= 1'b0;
    if (n >= Timeout)
    begin
      errors++;
      $display("Write address channel stalled at address 0x%h", addr);
      return;
    end
    n = 0;
    @(negedge clk);
    while (!BVALID && n < Timeout)
    begin
      @(negedge clk);
      n++;
    end
    if (!BVALID)
    begin
      errors++;
      $display("Write response channel stalled at address 0x%h", addr);
      return;
    end
    resp = BRESP;
    repeat (randDelay())
    begin
      @(negedge clk);
      if (!BVALID || BRESP !== resp)
      begin
        errors++;
        $display("Write response dropped or changed while BREADY was low");
      end
    end
    @(posedge clk);
    BREADY <= 1'b1;
    @(posedge clk);
    BREADY <= 1'b0;
    checkWord("BRESP", 32'd0, {30'd0, resp});
  endtask

  task automatic axiRead(input logic [11:0] addr, output logic [31:0] data);
    int n;
    data = '0;
    @(posedge clk);
    ARADDR  <= addr;
    ARVALID <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!ARREADY && n < Timeout)
    begin
      @(negedge clk);
      n++;
    end
    @(posedge clk);
    ARVALID <= 1'b0;
    if (n >= Timeout)
    begin
      errors++;
      $display("Read address channel stalled at address 0x%h", addr);
      return;
    end
    n = 0;
    @(negedge clk);
    while (!RVALID && n < Timeout)
    begin
      @(negedge clk);
      n++;
    end
    if (!RVALID)
    begin
      errors++;
      $display("Read data channel stalled at address 0x%h", addr);
      return;
    end
    data = RDATA;
    checkWord("RRESP", 32'd0, {30'd0, RRESP});
    repeat (randDelay())
    begin
      @(negedge clk);
      if (!RVALID || RDATA !== data)
      begin
        errors++;
        $display("Read data dropped or changed while RREADY was low");
      end
    end
    @(posedge clk);
    RREADY <= 1'b1;
    @(posedge clk);
    RREADY <= 1'b0;
  endtask

  task automatic writeOperand(input logic [11:0] base, input logic [Span-1:0] value,
                              input string name);
    logic [31:0] data;
    for (int i = 0; i < `MP_WORDS; i++)
      axiWrite(12'(base + 4 * i), value[32*i +: 32]);
    for (int i = 0; i < `MP_WORDS; i++)
    begin
      axiRead(12'(base + 4 * i), data);
      checkWord($sformatf("%s[%0d]", name, i), value[32*i +: 32], data);
    end
  endtask

  task automatic waitDone();
    logic [31:0] status;
    int          n;
    status = '0;
    n = 0;
    while (!status[1] && n < Timeout)
    begin
      axiRead(`MP_REG_STATUS, status);
      n++;
    end
    if (!status[1])
    begin
      errors++;
      $display("Operation never reported done in STATUS");
    end
  endtask

  task automatic runOp(input logic [Span-1:0] a, input logic [Span-1:0] b,
                       input logic [Span-1:0] m);
    logic [Span-1:0] one;
    logic [Span-1:0] mneg;
    logic [Span-1:0] expected;
    logic [31:0]     data;
    one = 1;
    mneg = (one << `MP_ADD_WIDTH) - m;
    expected = a + b;
    if (expected >= m)
      expected = expected - m;  // Both operands below M
    writeOperand(`MP_BASE_A, a, "A");
    writeOperand(`MP_BASE_B, b, "B");
    writeOperand(`MP_BASE_MNEG, mneg, "MNEG");
    @(posedge clk);
    doneLowSeen <= 1'b0;
    axiWrite(`MP_REG_CTRL, 32'h1);
    waitDone();
    if (!doneLowSeen)
    begin
      errors++;
      $display("Start did not clear the done flag");
    end
    axiRead(`MP_REG_CYCLES, data);
    checkWord("CYCLES", 32'd4, data);
    axiRead(`MP_REG_STATUS, data);
    checkWord("STATUS", 32'h2, data);  // Done set, busy clear
    for (int i = 0; i < `MP_WORDS; i++)
    begin
      axiRead(12'(`MP_BASE_RES + 4 * i), data);
      checkWord($sformatf("RES[%0d]", i), expected[32*i +: 32], data);
    end
  endtask

  task automatic randomOp();
    logic [Span-1:0] m;
    logic [Span-1:0] a;
    logic [Span-1:0] b;
    m = randBits(`MP_WIDTH);
    m[`MP_WIDTH-1] = 1'b1;
    a = randBits(`MP_WIDTH);
    b = randBits(`MP_WIDTH);
    if (a >= m)
      a = a - m;
    if (b >= m)
      b = b - m;
    runOp(a, b, m);
  endtask

  initial
  begin
    logic [Span-1:0] m;
    logic [Span-1:0] a;
    logic [Span-1:0] one;
    logic [31:0]     data;
    clk = 1'b0;
    rst = 1'b1;
    AWADDR = '0;
    AWVALID = 1'b0;
    WDATA = '0;
    WSTRB = 4'hF;
    WVALID = 1'b0;
    BREADY = 1'b0;
    ARADDR = '0;
    ARVALID = 1'b0;
    RREADY = 1'b0;
    lfsr = 32'h34b4_cb78;
    errors = 0;
    checks = 0;
    readyBits = 0;
    doneLowSeen = 1'b0;
    one = 1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    axiRead(`MP_REG_STATUS, data);
    checkWord("STATUS", 32'd0, data);
    axiRead(`MP_REG_CYCLES, data);
    checkWord("CYCLES", 32'd0, data);
    for (int i = 0; i < `MP_WORDS; i++)
    begin
      axiRead(12'(`MP_BASE_RES + 4 * i), data);
      checkWord($sformatf("RES[%0d]", i), 32'd0, data);
    end
    axiRead(12'h500, data);  // Unmapped
    checkWord("RDATA", 32'd0, data);

    readyBits = 1;
    repeat (20) randomOp();

    m = randBits(`MP_WIDTH) | (one << (`MP_WIDTH - 1));
    a = randBits(`MP_WIDTH);
    if (a >= m)
      a = a - m;
    if (a == 0)
      a = 1;
    runOp(a, m - a, m);      // Sum equals M
    runOp(m - 1, m - 1, m);
    m = (one << `MP_WIDTH) - 1;
    runOp(m - 1, one, m);    // Reduce pass ripples through every limb
    runOp('0, '0, m);

    readyBits = 3;           // Back-pressure on BREADY and RREADY
    repeat (5) randomOp();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire
